//--- Makefile
TOP = classifierTb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f project.f \
		--top-module $(TOP) -o V$(TOP)

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir

//--- hdl/classifierTop.sv
`timescale 1ns/1ps
`default_nettype none

module classifierTop #(
	parameter int FifoDepth = 8
) (
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire neuralPkg::inVector_t inData,
	output logic inCredit,
	input wire outCredit,
	output logic outValid,
	output neuralPkg::scoreVector_t outData
);

	`include "layerWeights.svh"

	logic hiddenValid;
	neuralPkg::hiddenVector_t hiddenData;
	logic scoreValid;
	neuralPkg::scoreVector_t scoreData;
	logic fifoPop;
	logic fifoEmpty;

	// 15 inputs to 10 hidden activations.
	denseLayer #(
		.NumInputs(neuralPkg::InputCount),
		.NumNeurons(neuralPkg::HiddenCount),
		.Weights(HiddenWeights),
		.Biases(HiddenBiases)
	) hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.activations(inData.act),
		.outValid(hiddenValid),
		.results(hiddenData.act)
	);

	// 10 hidden activations to 4 scores.
	denseLayer #(
		.NumInputs(neuralPkg::HiddenCount),
		.NumNeurons(neuralPkg::ScoreCount),
		.Weights(OutputWeights),
		.Biases(OutputBiases)
	) scoreLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.activations(hiddenData.act),
		.outValid(scoreValid),
		.results(scoreData.act)
	);

	// Holds scores until the consumer grants a credit.
	resultFifo #(
		.Depth(FifoDepth)
	) fifo (
		.clk(clk),
		.reset(reset),
		.push(scoreValid),
		.pushData(scoreData),
		.pop(fifoPop),
		.popData(outData),
		.empty(fifoEmpty)
	);

	creditLink #(
		.Depth(FifoDepth)
	) link (
		.clk(clk),
		.reset(reset),
		.outCredit(outCredit),
		.empty(fifoEmpty),
		.pop(fifoPop),
		.inCredit(inCredit),
		.outValid(outValid)
	);

endmodule

`default_nettype wire

//--- hdl/creditLink.sv
`timescale 1ns/1ps
`default_nettype none

module creditLink #(
	parameter int Depth = 8
) (
	input wire clk,
	input wire reset,
	input wire outCredit,
	input wire empty,
	output logic pop,
	output logic inCredit,
	output logic outValid
);

	// Headroom lets the consumer grant ahead of the data.
	localparam int CreditWidth = $clog2(Depth + 1) + 4;

	typedef logic [CreditWidth-1:0] credit_t;

	credit_t credits;
	logic grant;

	// One transfer whenever there is both data and a credit.
	assign grant = !empty && (credits != '0);

	assign pop = grant;
	assign outValid = grant;
	assign inCredit = grant; // Freed slot goes back upstream.

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credits <= '0;
		end
		else
		begin
			credits <= credits + credit_t'(outCredit) - credit_t'(grant);
		end
	end

endmodule

`default_nettype wire

//--- hdl/denseLayer.sv
`timescale 1ns/1ps
`default_nettype none

module denseLayer #(
	parameter int NumInputs = neuralPkg::InputCount,
	parameter int NumNeurons = neuralPkg::HiddenCount,
	parameter neuralPkg::activation_t [0:NumInputs*NumNeurons-1] Weights = '0,
	parameter neuralPkg::bias_t [0:NumNeurons-1] Biases = '0
) (
	input wire clk,
	input wire reset,
	input wire inValid,
	input wire neuralPkg::activation_t [NumInputs-1:0] activations,
	output logic outValid,
	output neuralPkg::activation_t [NumNeurons-1:0] results
);

	localparam int Latency = neuralPkg::NeuronLatency;

	logic [Latency-1:0] validPipe;

	// Valid follows the data through the three neuron stages.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[Latency-2:0], inValid};
		end
	end

	assign outValid = validPipe[Latency-1];

	generate
		for (genvar n = 0; n < NumNeurons; n++)
		begin : neurons
			// Row n of the weight table.
			neuron #(
				.NumInputs(NumInputs),
				.Weights(Weights[n*NumInputs +: NumInputs]),
				.Bias(Biases[n])
			) node (
				.clk(clk),
				.reset(reset),
				.activations(activations),
				.result(results[n])
			);
		end
	endgenerate

endmodule

`default_nettype wire

//--- hdl/neuralPkg.sv
`default_nettype none

package neuralPkg;

	localparam int ActWidth = 8;
	localparam int ProductWidth = 2 * ActWidth;
	localparam int BiasWidth = 16;
	localparam int AccumWidth = 23; // Room for 15 products plus bias.
	localparam int FracBits = 6; // Fraction bits dropped at the output.
	localparam int ActMax = (1 << (ActWidth - 1)) - 1;
	localparam int NeuronLatency = 3;

	localparam int InputCount = 15;
	localparam int HiddenCount = 10;
	localparam int ScoreCount = 4;

	typedef logic signed [ActWidth-1:0] activation_t;
	typedef logic signed [ProductWidth-1:0] product_t;
	typedef logic signed [BiasWidth-1:0] bias_t;
	typedef logic signed [AccumWidth-1:0] accum_t;

	// Element 0 sits in the low byte.
	typedef struct packed
	{
		activation_t [InputCount-1:0] act;
	} inVector_t;

	typedef struct packed
	{
		activation_t [HiddenCount-1:0] act;
	} hiddenVector_t;

	typedef struct packed
	{
		activation_t [ScoreCount-1:0] act;
	} scoreVector_t;

endpackage

`default_nettype wire

//--- hdl/neuron.sv
`timescale 1ns/1ps
`default_nettype none

module neuron #(
	parameter int NumInputs = neuralPkg::InputCount,
	parameter neuralPkg::activation_t [0:NumInputs-1] Weights = '0,
	parameter neuralPkg::bias_t Bias = '0
) (
	input wire clk,
	input wire reset,
	input wire neuralPkg::activation_t [NumInputs-1:0] activations,
	output neuralPkg::activation_t result
);

	localparam int RoundWidth = neuralPkg::AccumWidth - neuralPkg::FracBits;

	neuralPkg::activation_t activationReg [NumInputs];
	neuralPkg::product_t products [NumInputs];
	neuralPkg::accum_t sumNext;
	neuralPkg::accum_t sumReg;
	logic [RoundWidth-1:0] roundedSum;

	// Stage 1 captures the inputs.
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NumInputs; i++)
		begin
			activationReg[i] <= activations[i];
		end
	end

	// Products are sign-extended to 16 bits, then summed onto the bias.
	always_comb
	begin
		sumNext = Bias;
		for (int i = 0; i < NumInputs; i++)
		begin
			products[i] = activationReg[i] * $signed(Weights[i]);
			sumNext = sumNext + products[i];
		end
	end

	always_ff @(posedge clk)
	begin
		sumReg <= sumNext; // Stage 2.
	end

	// Only meaningful when the sum is non-negative.
	assign roundedSum = {1'b0, sumReg[neuralPkg::AccumWidth-2:neuralPkg::FracBits]}
		+ RoundWidth'(sumReg[neuralPkg::FracBits-1]);

	// Stage 3 is ReLU, round and saturate.
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
		end
		else if (sumReg[neuralPkg::AccumWidth-1])
		begin
			result <= '0; // Negative sum.
		end
		else if (roundedSum > RoundWidth'(neuralPkg::ActMax))
		begin
			result <= neuralPkg::activation_t'(neuralPkg::ActMax);
		end
		else
		begin
			result <= neuralPkg::activation_t'(roundedSum[neuralPkg::ActWidth-1:0]);
		end
	end

endmodule

`default_nettype wire

//--- hdl/resultFifo.sv
`timescale 1ns/1ps
`default_nettype none

module resultFifo #(
	parameter int Depth = 8
) (
	input wire clk,
	input wire reset,
	input wire push,
	input wire neuralPkg::scoreVector_t pushData,
	input wire pop,
	output neuralPkg::scoreVector_t popData,
	output logic empty
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	typedef logic [PtrWidth-1:0] ptr_t;
	typedef logic [CountWidth-1:0] count_t;

	neuralPkg::scoreVector_t mem [Depth];
	ptr_t readPtr;
	ptr_t writePtr;
	count_t count;

	// Wraps at Depth, which need not be a power of two.
	function automatic ptr_t nextPtr(ptr_t ptr);
		if (ptr == ptr_t'(Depth - 1))
			return '0;
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			mem[writePtr] <= pushData;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				writePtr <= nextPtr(writePtr);
			if (pop)
				readPtr <= nextPtr(readPtr);
			count <= count + count_t'(push) - count_t'(pop);
		end
	end

	assign popData = mem[readPtr]; // Head entry shows without a read delay.
	assign empty = (count == '0);

endmodule

`default_nettype wire

//--- include/layerWeights.svh
localparam neuralPkg::activation_t [0:neuralPkg::InputCount*neuralPkg::HiddenCount-1]
	HiddenWeights = {
		-8'sd18, -8'sd31, 8'sd9, -8'sd31, -8'sd4, -8'sd12, 8'sd23, 8'sd31,
		-8'sd21, -8'sd12, -8'sd17, 8'sd11, 8'sd4, -8'sd12, 8'sd15,
		8'sd12, -8'sd7, 8'sd25, 8'sd3, -8'sd19, 8'sd8, -8'sd26, 8'sd14,
		8'sd5, -8'sd11, 8'sd30, -8'sd2, 8'sd17, -8'sd9, 8'sd6,
		-8'sd5, 8'sd22, -8'sd14, 8'sd27, 8'sd10, -8'sd3, -8'sd29, 8'sd1,
		8'sd19, -8'sd24, 8'sd7, 8'sd13, -8'sd8, 8'sd26, -8'sd16,
		8'sd31, 8'sd4, -8'sd10, -8'sd22, 8'sd16, -8'sd27, 8'sd2, 8'sd9,
		-8'sd13, 8'sd20, -8'sd6, -8'sd30, 8'sd24, 8'sd11, -8'sd1,
		-8'sd25, 8'sd18, 8'sd6, -8'sd15, 8'sd29, -8'sd9, 8'sd12, -8'sd20,
		8'sd3, 8'sd28, -8'sd17, 8'sd8, -8'sd4, -8'sd23, 8'sd14,
		8'sd7, -8'sd28, 8'sd19, 8'sd11, -8'sd2, 8'sd24, -8'sd13, 8'sd5,
		-8'sd31, 8'sd9, 8'sd15, -8'sd18, 8'sd21, -8'sd6, 8'sd27,
		8'sd16, 8'sd10, -8'sd21, -8'sd4, 8'sd8, 8'sd13, 8'sd30, -8'sd11,
		-8'sd26, 8'sd2, -8'sd14, 8'sd23, -8'sd7, 8'sd18, -8'sd3,
		-8'sd9, -8'sd16, 8'sd28, 8'sd20, -8'sd24, 8'sd5, -8'sd1, 8'sd17,
		8'sd11, -8'sd29, 8'sd26, -8'sd12, 8'sd9, 8'sd4, -8'sd22,
		8'sd23, -8'sd3, -8'sd8, 8'sd6, -8'sd30, 8'sd19, 8'sd15, -8'sd27,
		8'sd14, 8'sd7, -8'sd20, 8'sd1, 8'sd29, -8'sd15, 8'sd10,
		-8'sd14, 8'sd27, 8'sd3, -8'sd18, 8'sd12, -8'sd6, -8'sd23, 8'sd21,
		-8'sd10, 8'sd16, 8'sd2, 8'sd25, -8'sd28, 8'sd13, -8'sd5
	};

localparam neuralPkg::bias_t [0:neuralPkg::HiddenCount-1]
	HiddenBiases = {
		16'sd1024, -16'sd512, 16'sd256, 16'sd768, -16'sd128,
		16'sd384, 16'sd0, -16'sd640, 16'sd896, 16'sd192
	};

localparam neuralPkg::activation_t [0:neuralPkg::HiddenCount*neuralPkg::ScoreCount-1]
	OutputWeights = {
		8'sd14, -8'sd9, 8'sd21, -8'sd6, 8'sd11,
		-8'sd17, 8'sd8, 8'sd3, -8'sd12, 8'sd19,
		-8'sd7, 8'sd16, -8'sd13, 8'sd22, -8'sd4,
		8'sd9, -8'sd20, 8'sd15, 8'sd6, -8'sd11,
		8'sd10, 8'sd5, -8'sd18, -8'sd8, 8'sd23,
		-8'sd3, 8'sd12, -8'sd21, 8'sd17, -8'sd2,
		-8'sd15, 8'sd20, 8'sd4, 8'sd13, -8'sd10,
		8'sd24, -8'sd6, -8'sd1, -8'sd19, 8'sd7
	};

localparam neuralPkg::bias_t [0:neuralPkg::ScoreCount-1]
	OutputBiases = {
		16'sd512, -16'sd256, 16'sd128, -16'sd384
	};

//--- project.f
+incdir+include
hdl/neuralPkg.sv
hdl/neuron.sv
hdl/denseLayer.sv
hdl/resultFifo.sv
hdl/creditLink.sv
hdl/classifierTop.sv
tests/classifierTb.sv

//--- tests/classifierTb.sv
`timescale 1ns/1ps
`default_nettype none

module classifierTb;

	localparam int FifoDepth = 8;
	localparam int InputCount = neuralPkg::InputCount;
	localparam int HiddenCount = neuralPkg::HiddenCount;
	localparam int ScoreCount = neuralPkg::ScoreCount;
	localparam int RandomCount = 40;
	localparam int Timeout = 200; // Cycles per wait.
	localparam logic [31:0] Seed = 32'hfbf9_8ee5;

	`include "layerWeights.svh"

	logic clk;
	logic reset;
	logic inValid;
	neuralPkg::inVector_t inData;
	logic inCredit;
	logic outCredit;
	logic outValid;
	neuralPkg::scoreVector_t outData;

	neuralPkg::scoreVector_t expected [$];
	neuralPkg::scoreVector_t want;
	logic [31:0] dataState;
	logic [31:0] creditState;
	int errors;
	int sent;
	int received;
	int returned;
	int sourceCredits;
	int unusedCredits; // Granted downstream credits not yet used.
	logic creditGiven;
	logic timedOut;

	classifierTop #(
		.FifoDepth(FifoDepth)
	) uut (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inCredit(inCredit),
		.outCredit(outCredit),
		.outValid(outValid),
		.outData(outData)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// Negative sums give zero, others round half up over 64 and cap at 127.
	function automatic neuralPkg::activation_t neuronRule(input int sum);
		int scaled;
		if (sum < 0)
			return '0;
		scaled = (sum + 32) / 64;
		if (scaled > 127)
			return 8'sd127;
		return neuralPkg::activation_t'(scaled);
	endfunction

	function automatic int hiddenSum(input neuralPkg::inVector_t vec, input int n);
		int sum;
		sum = int'(HiddenBiases[n]);
		for (int i = 0; i < InputCount; i++)
			sum += int'($signed(vec.act[i])) * int'($signed(HiddenWeights[n*InputCount + i]));
		return sum;
	endfunction

	function automatic neuralPkg::scoreVector_t modelScores(input neuralPkg::inVector_t vec);
		neuralPkg::hiddenVector_t hidden;
		neuralPkg::scoreVector_t scores;
		int sum;
		for (int n = 0; n < HiddenCount; n++)
			hidden.act[n] = neuronRule(hiddenSum(vec, n));
		for (int n = 0; n < ScoreCount; n++)
		begin
			sum = int'(OutputBiases[n]);
			for (int i = 0; i < HiddenCount; i++)
				sum += int'($signed(hidden.act[i]))
					* int'($signed(OutputWeights[n*HiddenCount + i]));
			scores.act[n] = neuronRule(sum);
		end
		return scores;
	endfunction

	function automatic neuralPkg::inVector_t randomVector();
		neuralPkg::inVector_t vec;
		for (int i = 0; i < InputCount; i++)
		begin
			dataState = lcgStep(dataState);
			vec.act[i] = neuralPkg::activation_t'($signed(dataState[23:16]) >>> 1);
		end
		return vec;
	endfunction

	// Loads every input whose hidden neuron 0 weight has the chosen sign.
	function automatic neuralPkg::inVector_t biasedVector(input bit positive);
		neuralPkg::inVector_t vec;
		vec = '0;
		for (int i = 0; i < InputCount; i++)
			if (positive ? ($signed(HiddenWeights[i]) > 0) : ($signed(HiddenWeights[i]) < 0))
				vec.act[i] = 8'sd100;
		return vec;
	endfunction

	function automatic neuralPkg::inVector_t roundingVector();
		neuralPkg::inVector_t vec;
		int sum;
		for (int v = 1; v < 128; v++)
		begin
			vec = '0;
			vec.act[0] = neuralPkg::activation_t'(v);
			sum = hiddenSum(vec, 0);
			if (sum >= 0 && sum[5] && (sum >>> 6) < 126)
				return vec;
		end
		return '0;
	endfunction

	task automatic reportTimeout(input string what);
		if (!timedOut)
		begin
			$display("Timeout: %s", what);
			errors++;
		end
		timedOut = 1'b1;
	endtask

	task automatic sendVector(input neuralPkg::inVector_t vec);
		int cycles;
		cycles = 0;
		while (sourceCredits == 0 && cycles < Timeout && !timedOut)
		begin
			@(negedge clk);
			cycles++;
		end
		if (sourceCredits == 0)
			reportTimeout("no upstream credit came back for the next vector");
		else
		begin
			inValid = 1'b1;
			inData = vec;
			sourceCredits--;
			sent++;
			expected.push_back(modelScores(vec));
			@(negedge clk);
			inValid = 1'b0;
		end
	endtask

	task automatic grantCredits(input int count);
		int gap;
		for (int k = 0; k < count; k++)
		begin
			creditState = lcgStep(creditState);
			gap = int'(creditState[31:30]); // Zero to three idle cycles.
			repeat (gap) @(negedge clk);
			outCredit = 1'b1;
			@(negedge clk);
			outCredit = 1'b0;
		end
	endtask

	task automatic waitForDrain();
		int cycles;
		cycles = 0;
		while (expected.size() != 0 && cycles < Timeout && !timedOut)
		begin
			@(negedge clk);
			cycles++;
		end
		if (expected.size() != 0)
			reportTimeout("score vectors still missing at the end of the run");
	endtask

	// Samples the DUT like a flop, on the pre-edge values.
	always @(posedge clk)
	begin
		if (!reset)
		begin
			assert (!outValid || unusedCredits > 0)
			else
			begin
				errors++;
				$display("outValid asserted at %0t ns with no unused downstream credit", $time);
			end
			if (!creditGiven)
			begin
				assert (!outValid && !inCredit)
				else
				begin
					errors++;
					$display("error at %0t ns: outValid = %b, inCredit = %b, expected 0 and 0",
						$time, outValid, inCredit);
				end
			end
			if (outValid)
			begin
				received++;
				if (expected.size() == 0)
				begin
					errors++;
					$display("outValid at %0t ns with no score vector outstanding", $time);
				end
				else
				begin
					want = expected.pop_front();
					assert (outData == want)
					else
					begin
						errors++;
						$display("error at %0t ns: outData = %h, expected %h", $time, outData, want);
					end
				end
			end
			if (inCredit)
			begin
				returned++;
				sourceCredits++;
			end
			if (outCredit)
				creditGiven = 1'b1;
			unusedCredits = unusedCredits + int'(outCredit) - int'(outValid);
		end
	end

	initial
	begin
		neuralPkg::inVector_t lowVector;
		neuralPkg::inVector_t highVector;
		neuralPkg::inVector_t roundVector;
		int held;
		int sum;
		$timeformat(-9, 0, "", 0);
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		outCredit = 1'b0;
		dataState = Seed;
		creditState = lcgStep(Seed);
		errors = 0;
		sent = 0;
		received = 0;
		returned = 0;
		sourceCredits = FifoDepth;
		unusedCredits = 0;
		creditGiven = 1'b0;
		timedOut = 1'b0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// No downstream credit yet, so the FIFO fills and the source runs dry.
		for (int k = 0; k < FifoDepth; k++)
			sendVector(randomVector());
		held = 0;
		while (sourceCredits == 0 && held < 30)
		begin
			@(negedge clk);
			held++;
		end
		assert (sourceCredits == 0 && returned == 0 && received == 0)
		else
		begin
			errors++;
			$display("inCredit or outValid seen while downstream credit was withheld");
		end

		// Credits resume while random vectors go in at full credit rate.
		fork
			begin
				for (int k = 0; k < RandomCount; k++)
					sendVector(randomVector());
			end
			begin
				grantCredits(RandomCount + FifoDepth);
			end
		join

		lowVector = biasedVector(1'b0);
		highVector = biasedVector(1'b1);
		roundVector = roundingVector();
		assert (hiddenSum(lowVector, 0) < 0)
		else
		begin
			errors++;
			$display("directed vector does not drive hidden neuron 0 negative");
		end
		assert (neuronRule(hiddenSum(highVector, 0)) == 8'sd127)
		else
		begin
			errors++;
			$display("directed vector does not saturate hidden neuron 0");
		end
		sum = hiddenSum(roundVector, 0);
		assert (sum >= 0 && sum[5])
		else
		begin
			errors++;
			$display("directed vector does not set the rounding bit of hidden neuron 0");
		end
		fork
			begin
				sendVector(lowVector);
				sendVector(highVector);
				sendVector(roundVector);
			end
			begin
				grantCredits(3);
			end
		join
		waitForDrain();

		assert (received == sent)
		else
		begin
			errors++;
			$display("error at %0t ns: outValid count = %0d, expected %0d", $time, received, sent);
		end
		assert (returned == received)
		else
		begin
			errors++;
			$display("error at %0t ns: inCredit count = %0d, expected %0d",
				$time, returned, received);
		end
		assert (unusedCredits == 0 && sourceCredits == FifoDepth)
		else
		begin
			errors++;
			$display("credit counts did not settle at the end of the run");
		end

		$display("Closing: %0d errors, %0d sent, %0d received, %0d credits returned",
			errors, sent, received, returned);
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire
